//--- hdl/ooo_pkg.sv
/* shared types and constants for the out-of-order core
   imported by every RTL block and by the testbench */
`default_nettype none

package ooo_pkg;

    localparam int NUM_RS      = 4;  // entries 1..NUM_RS, tag 0 is "no producer"
    localparam int NUM_REGS    = 8;
    localparam int MULT_STAGES = 3;

    typedef logic [15:0] data_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [2:0]  tag_t;

    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL   // low 16 bits of the product
    } op_e;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_class_e;

    typedef struct packed {
        op_e      op;
        reg_idx_t dest;
        reg_idx_t src_a;
        reg_idx_t src_b;
        data_t    imm;     // only OP_LI reads this
    } dispatch_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;        // producer while not ready
        data_t value;
    } operand_t;

    typedef struct packed {
        op_e      op;
        operand_t a;
        operand_t b;
        reg_idx_t dest;
    } rs_entry_in_t;

    // dest rides along so the units can fill in the CDB dest field
    typedef struct packed {
        logic     valid;
        op_e      op;
        tag_t     tag;
        data_t    value_a;
        data_t    value_b;
        reg_idx_t dest;
    } issue_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t dest;
        data_t    value;
    } cdb_t;

    function automatic fu_class_e op_class(op_e op);
        return (op == OP_MUL) ? FU_MULT : FU_ALU;
    endfunction

    // lower half of the station serves the ALU, upper half the multiplier
    function automatic fu_class_e entry_class(int unsigned idx);
        return (idx <= NUM_RS / 2) ? FU_ALU : FU_MULT;
    endfunction

endpackage

`default_nettype wire

//--- hdl/rename_stage.sv
/* register file and map table; renames each dispatched instruction into
   a station entry and retires results from the CDB into the registers */
`default_nettype none

module rename_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  ooo_pkg::dispatch_t    dispatch_instr,
    input  ooo_pkg::tag_t         alloc_tag,
    input  ooo_pkg::cdb_t         cdb,
    input  ooo_pkg::reg_idx_t     read_index,
    output ooo_pkg::rs_entry_in_t rs_entry,
    output ooo_pkg::data_t        read_value
);
    import ooo_pkg::*;

    data_t regs    [NUM_REGS];
    tag_t  map_tag [NUM_REGS];   // 0 when the register holds its latest value

    // value from the register, from the bus this cycle, or wait on a tag
    function automatic operand_t lookup(tag_t producer, data_t reg_value, cdb_t bus);
        operand_t opnd;
        if (producer == '0) begin
            opnd = '{ready: 1'b1, tag: '0, value: reg_value};
        end else if (bus.valid && bus.tag == producer) begin
            opnd = '{ready: 1'b1, tag: '0, value: bus.value};
        end else begin
            opnd = '{ready: 1'b0, tag: producer, value: '0};
        end
        return opnd;
    endfunction

    always_comb begin
        rs_entry.op   = dispatch_instr.op;
        rs_entry.dest = dispatch_instr.dest;
        if (dispatch_instr.op == OP_LI) begin
            rs_entry.a = '{ready: 1'b1, tag: '0, value: dispatch_instr.imm};
            rs_entry.b = '{ready: 1'b1, tag: '0, value: '0};  // unused
        end else begin
            rs_entry.a = lookup(map_tag[dispatch_instr.src_a],
                                regs[dispatch_instr.src_a], cdb);
            rs_entry.b = lookup(map_tag[dispatch_instr.src_b],
                                regs[dispatch_instr.src_b], cdb);
        end
    end

    assign read_value = regs[read_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i]    <= '0;
                map_tag[i] <= '0;
            end
        end else begin
            // a stale producer is dropped, only the newest writer lands
            if (cdb.valid && map_tag[cdb.dest] == cdb.tag) begin
                regs[cdb.dest]    <= cdb.value;
                map_tag[cdb.dest] <= '0;
            end
            // a remap in the same cycle wins over the clear above
            if (dispatch_valid) begin
                map_tag[dispatch_instr.dest] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/reservation_station.sv
/* four-entry reservation station with fixed unit classes; allocates on
   dispatch, wakes operands from the CDB and picks one issue per class */
`default_nettype none

module reservation_station (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  ooo_pkg::rs_entry_in_t rs_entry,
    input  ooo_pkg::cdb_t         cdb,
    input  logic                  alu_hold,
    output ooo_pkg::tag_t         alloc_tag,
    output logic                  alu_avail,
    output logic                  mult_avail,
    output ooo_pkg::issue_t       alu_issue,
    output ooo_pkg::issue_t       mult_issue
);
    import ooo_pkg::*;

    logic [NUM_RS:1] busy;
    logic [NUM_RS:1] issued;     // sent to a unit, waiting for broadcast
    logic [NUM_RS:1] ready;
    rs_entry_in_t    entry [1:NUM_RS];

    function automatic issue_t issue_packet(rs_entry_in_t e, tag_t tag);
        issue_t pkt;
        pkt.valid   = 1'b1;
        pkt.op      = e.op;
        pkt.tag     = tag;
        pkt.value_a = e.a.value;
        pkt.value_b = e.b.value;
        pkt.dest    = e.dest;
        return pkt;
    endfunction

    // scan downwards so the lowest free entry of the class is left in alloc_tag
    always_comb begin
        alloc_tag  = '0;
        alu_avail  = 1'b0;
        mult_avail = 1'b0;
        for (int i = NUM_RS; i >= 1; i--) begin
            if (!busy[i]) begin
                if (entry_class(i) == FU_ALU) begin
                    alu_avail = 1'b1;
                end else begin
                    mult_avail = 1'b1;
                end
                if (entry_class(i) == op_class(rs_entry.op)) begin
                    alloc_tag = tag_t'(i);
                end
            end
        end
    end

    always_comb begin
        for (int i = 1; i <= NUM_RS; i++) begin
            ready[i] = busy[i] && !issued[i] && entry[i].a.ready && entry[i].b.ready;
        end
    end

    // lowest ready entry per class
    always_comb begin
        alu_issue  = '0;
        mult_issue = '0;
        for (int i = NUM_RS; i >= 1; i--) begin
            if (ready[i]) begin
                if (entry_class(i) == FU_ALU) begin
                    alu_issue = issue_packet(entry[i], tag_t'(i));
                end else begin
                    mult_issue = issue_packet(entry[i], tag_t'(i));
                end
            end
        end
        alu_issue.valid = alu_issue.valid && !alu_hold;  // multiplier owns next CDB slot
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int i = 1; i <= NUM_RS; i++) begin
                if (dispatch_valid && alloc_tag == tag_t'(i)) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                end else begin
                    if (cdb.valid && cdb.tag == tag_t'(i)) begin
                        busy[i] <= 1'b0;  // freed at end of its broadcast
                    end
                    if ((alu_issue.valid && alu_issue.tag == tag_t'(i)) ||
                        (mult_issue.valid && mult_issue.tag == tag_t'(i))) begin
                        issued[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // operand payload and wakeup
    always_ff @(posedge clock) begin
        for (int i = 1; i <= NUM_RS; i++) begin
            if (dispatch_valid && alloc_tag == tag_t'(i)) begin
                entry[i] <= rs_entry;
            end else if (cdb.valid && busy[i]) begin
                if (!entry[i].a.ready && entry[i].a.tag == cdb.tag) begin
                    entry[i].a <= '{ready: 1'b1, tag: '0, value: cdb.value};
                end
                if (!entry[i].b.ready && entry[i].b.tag == cdb.tag) begin
                    entry[i].b <= '{ready: 1'b1, tag: '0, value: cdb.value};
                end
            end
        end
    end

    // the source must check the availability flags before dispatching
    a_no_full_dispatch: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> alloc_tag != '0)
        else $error("dispatch into a full class, op %s", rs_entry.op.name());

    // every broadcast comes back to an entry that was issued and still waits
    a_cdb_owner: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag inside {[1:NUM_RS]}) && busy[cdb.tag] && issued[cdb.tag])
        else $error("CDB tag %0d has no issued entry", cdb.tag);

    // product in the second multiplier stage, so no ALU issue this cycle
    a_alu_hold: assert property (@(posedge clock) disable iff (reset)
        $past(mult_issue.valid, MULT_STAGES - 1) |-> !alu_issue.valid)
        else $error("ALU issue during hold");

endmodule

`default_nettype wire

//--- hdl/exec_units.sv
/* one-cycle ALU and pipelined multiplier sharing the CDB; the multiplier
   wins the bus and asks the station to hold ALU issue one cycle ahead */
`default_nettype none

module exec_units (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t alu_issue,
    input  ooo_pkg::issue_t mult_issue,
    output ooo_pkg::cdb_t   cdb,
    output logic            alu_hold
);
    import ooo_pkg::*;

    logic     alu_valid;
    tag_t     alu_tag;
    data_t    alu_result;
    data_t    alu_next;

    logic [MULT_STAGES:1] mult_valid;
    tag_t     mult_tag  [1:MULT_STAGES];
    data_t    pp_lo;                       // a * b[7:0]
    data_t    pp_hi;                       // a * b[15:8], shifted later
    data_t    mult_prod [2:MULT_STAGES];
    reg_idx_t dest_table [1:NUM_RS];       // written at issue, read at broadcast

    always_comb begin
        case (alu_issue.op)
            OP_LI:   alu_next = alu_issue.value_a;
            OP_ADD:  alu_next = alu_issue.value_a + alu_issue.value_b;
            OP_SUB:  alu_next = alu_issue.value_a - alu_issue.value_b;
            OP_XOR:  alu_next = alu_issue.value_a ^ alu_issue.value_b;
            default: alu_next = alu_issue.value_a;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid  <= 1'b0;
            mult_valid <= '0;
        end else begin
            alu_valid  <= alu_issue.valid;
            mult_valid <= {mult_valid[MULT_STAGES-1:1], mult_issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        alu_tag    <= alu_issue.tag;
        alu_result <= alu_next;

        mult_tag[1] <= mult_issue.tag;
        pp_lo       <= mult_issue.value_a * mult_issue.value_b[7:0];
        pp_hi       <= mult_issue.value_a * mult_issue.value_b[15:8];
        for (int s = 2; s <= MULT_STAGES; s++) begin
            mult_tag[s] <= mult_tag[s-1];
        end
        mult_prod[2] <= pp_lo + (pp_hi << 8);
        for (int s = 3; s <= MULT_STAGES; s++) begin
            mult_prod[s] <= mult_prod[s-1];
        end

        if (alu_issue.valid) begin
            dest_table[alu_issue.tag] <= alu_issue.dest;
        end
        if (mult_issue.valid) begin
            dest_table[mult_issue.tag] <= mult_issue.dest;
        end
    end

    // multiplier output first, otherwise the ALU register
    always_comb begin
        if (mult_valid[MULT_STAGES]) begin
            cdb.valid = 1'b1;
            cdb.tag   = mult_tag[MULT_STAGES];
            cdb.value = mult_prod[MULT_STAGES];
        end else begin
            cdb.valid = alu_valid;
            cdb.tag   = alu_tag;
            cdb.value = alu_result;
        end
        cdb.dest = dest_table[cdb.tag];
    end

    assign alu_hold = mult_valid[MULT_STAGES-1];  // product reaches the bus next cycle

    // relies on the station honouring alu_hold a cycle earlier
    a_no_cdb_collision: assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mult_valid[MULT_STAGES]))
        else $error("ALU and multiplier results collide on the CDB");

endmodule

`default_nettype wire

//--- hdl/ooo_core.sv
/* top of the out-of-order core: rename stage, reservation station and
   execution units joined by the dispatch path and the CDB */
`default_nettype none

module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  ooo_pkg::dispatch_t dispatch_instr,
    input  ooo_pkg::reg_idx_t  read_index,
    output logic               alu_avail,
    output logic               mult_avail,
    output ooo_pkg::cdb_t      cdb,
    output ooo_pkg::data_t     read_value
);
    import ooo_pkg::*;

    rs_entry_in_t rs_entry;
    tag_t         alloc_tag;
    issue_t       alu_issue;
    issue_t       mult_issue;
    logic         alu_hold;

    rename_stage u_rename (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .alloc_tag      (alloc_tag),
        .cdb            (cdb),
        .read_index     (read_index),
        .rs_entry       (rs_entry),
        .read_value     (read_value)
    );

    reservation_station u_rs (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .rs_entry       (rs_entry),
        .cdb            (cdb),
        .alu_hold       (alu_hold),
        .alloc_tag      (alloc_tag),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail),
        .alu_issue      (alu_issue),
        .mult_issue     (mult_issue)
    );

    exec_units u_exec (
        .clock      (clock),
        .reset      (reset),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue),
        .cdb        (cdb),
        .alu_hold   (alu_hold)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
/* testbench clock and reset source, 100 ns period
   reset is held for the first two rising edges */
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b0;  // released just after the second edge
    end

endmodule

`default_nettype wire

//--- tb/ooo_checker.sv
/* watches the core ports and compares them with a program-order model
   tracks station occupancy, expected broadcasts and register contents */
`default_nettype none

module ooo_checker (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  ooo_pkg::dispatch_t dispatch_instr,
    input  logic               alu_avail,
    input  logic               mult_avail,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               read_check,
    input  ooo_pkg::reg_idx_t  read_index,
    input  ooo_pkg::data_t     read_value,
    output logic               idle,
    output int                 error_count,
    output int                 check_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_pkg::*;

    data_t           model_regs [NUM_REGS];  // values in program order
    logic [NUM_RS:1] pending;                // dispatched, not yet broadcast
    data_t           exp_value  [1:NUM_RS];
    reg_idx_t        exp_dest   [1:NUM_RS];

    assign idle = (pending == '0);

    function automatic data_t expected_result(op_e op, data_t a, data_t b, data_t imm);
        logic [31:0] product;
        data_t       result;
        product = a * b;
        case (op)
            OP_LI:   result = imm;
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_XOR:  result = a ^ b;
            OP_MUL:  result = product[15:0];
            default: result = 'x;
        endcase
        return result;
    endfunction

    // upper half of the entries belongs to the multiplier
    function automatic tag_t lowest_free(logic is_mult);
        tag_t found;
        found = '0;
        for (int i = NUM_RS; i >= 1; i--) begin
            if (!pending[i] && ((i > NUM_RS / 2) == is_mult)) begin
                found = tag_t'(i);
            end
        end
        return found;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("FAIL %s: got %h expected %h at %0t", name, got, expected, $time);
            error_count++;
        end
    endtask

    always @(posedge clock or posedge reset) begin : check_edge
        tag_t  alloc;
        tag_t  free_tag;
        data_t value;
        if (reset) begin
            pending     = '0;
            error_count = 0;
            check_count = 0;
            for (int r = 0; r < NUM_REGS; r++) begin
                model_regs[r] = '0;
            end
        end else begin
            compare_value("alu_avail", alu_avail, lowest_free(1'b0) != '0);
            compare_value("mult_avail", mult_avail, lowest_free(1'b1) != '0);

            free_tag = '0;
            if (cdb.valid) begin
                check_count++;
                if (cdb.tag < 1 || cdb.tag > NUM_RS || !pending[cdb.tag]) begin
                    $display("ERROR broadcast of tag %0d which has no pending instruction",
                             cdb.tag);
                    error_count++;
                end else begin
                    compare_value("cdb.dest", cdb.dest, exp_dest[cdb.tag]);
                    compare_value("cdb.value", cdb.value, exp_value[cdb.tag]);
                    free_tag = cdb.tag;
                end
            end

            // allocation sees the broadcasting entry as still busy
            if (dispatch_valid) begin
                alloc = lowest_free(dispatch_instr.op == OP_MUL);
                if (alloc == '0) begin
                    $display("ERROR dispatch while its class has no free entry");
                    error_count++;
                end else begin
                    value = expected_result(dispatch_instr.op,
                                            model_regs[dispatch_instr.src_a],
                                            model_regs[dispatch_instr.src_b],
                                            dispatch_instr.imm);
                    model_regs[dispatch_instr.dest] = value;
                    exp_value[alloc] = value;
                    exp_dest[alloc]  = dispatch_instr.dest;
                    pending[alloc]   = 1'b1;
                end
            end
            if (free_tag != '0) begin
                pending[free_tag] = 1'b0;
            end

            if (read_check) begin
                compare_value($sformatf("read_value[%0d]", read_index), read_value,
                              model_regs[read_index]);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/ooo_tb.sv
/* testbench top for the out-of-order core; runs directed and random
   instruction streams and reports the checker's result */
`default_nettype none

module ooo_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_pkg::*;

    localparam int DRIVE_DELAY  = 10;
    localparam int WAIT_LIMIT   = 200;  // cycles per wait
    localparam int RANDOM_COUNT = 200;

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    dispatch_t dispatch_instr;
    reg_idx_t  read_index;
    logic      alu_avail;
    logic      mult_avail;
    cdb_t      cdb;
    data_t     read_value;
    logic      read_check;
    logic      idle;
    int        error_count;
    int        check_count;

    logic [31:0] lfsr_state;
    logic        timed_out;
    int          test_num;
    int          tests_failed;
    int          errors_before;

    tb_clock_gen u_clock (.clock(clock), .reset(reset));

    ooo_core DUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .read_index     (read_index),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail),
        .cdb            (cdb),
        .read_value     (read_value)
    );

    ooo_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .alu_avail      (alu_avail),
        .mult_avail     (mult_avail),
        .cdb            (cdb),
        .read_check     (read_check),
        .read_index     (read_index),
        .read_value     (read_value),
        .idle           (idle),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[14:0], lfsr_state[0]};
        end
    endtask

    task automatic step_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s at %0t", what, $time);
        timed_out = 1'b1;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (reset !== 1'b0 && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (reset !== 1'b0) begin
            report_timeout("reset never released");
        end
    endtask

    // one-cycle strobe, only once the class has a free entry
    task automatic dispatch(input op_e op, input reg_idx_t dest, input reg_idx_t src_a,
                            input reg_idx_t src_b, input data_t imm);
        int waited;
        if (timed_out) return;
        waited = 0;
        while (!(op == OP_MUL ? mult_avail : alu_avail) && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!(op == OP_MUL ? mult_avail : alu_avail)) begin
            report_timeout("no free station entry for a dispatch");
            return;
        end
        dispatch_instr.op    = op;
        dispatch_instr.dest  = dest;
        dispatch_instr.src_a = src_a;
        dispatch_instr.src_b = src_b;
        dispatch_instr.imm   = imm;
        dispatch_valid = 1'b1;
        step_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_broadcast();
        int waited;
        if (timed_out) return;
        waited = 0;
        while (!cdb.valid && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!cdb.valid) begin
            report_timeout("no CDB broadcast arrived");
        end
    endtask

    task automatic drain();
        int waited;
        if (timed_out) return;
        waited = 0;
        while (!idle && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!idle) begin
            report_timeout("station entries never drained");
        end
    endtask

    task automatic read_back_all();
        if (timed_out) return;
        for (int r = 0; r < NUM_REGS; r++) begin
            read_index = reg_idx_t'(r);
            read_check = 1'b1;
            step_cycle();
        end
        read_check = 1'b0;
    endtask

    task automatic run_random(input int count);
        logic [15:0] r_op;
        logic [15:0] r_dest;
        logic [15:0] r_a;
        logic [15:0] r_b;
        logic [15:0] r_imm;
        logic [15:0] r_gap;
        for (int k = 0; k < count; k++) begin
            take_bits(3, r_op);
            take_bits(3, r_dest);
            take_bits(3, r_a);
            take_bits(3, r_b);
            take_bits(16, r_imm);
            dispatch(op_e'(r_op[2:0] % 3'd5), reg_idx_t'(r_dest), reg_idx_t'(r_a),
                     reg_idx_t'(r_b), r_imm);
            take_bits(1, r_gap);
            if (r_gap[0]) begin
                step_cycle();  // occasional idle cycle
            end
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - errors_before;
        test_num++;
        if (errs == 0 && !timed_out) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors%s", test_num, name, errs,
                     timed_out ? ", timed out" : "");
            tests_failed++;
        end
        errors_before = error_count;
    endtask

    initial begin
        dispatch_valid = 1'b0;
        dispatch_instr = '0;
        read_index     = '0;
        read_check     = 1'b0;
        lfsr_state     = 32'h5b393f45;
        timed_out      = 1'b0;
        test_num       = 0;
        tests_failed   = 0;
        errors_before  = 0;
        wait_reset_release();

        for (int r = 0; r < NUM_REGS; r++) begin
            dispatch(OP_LI, reg_idx_t'(r), '0, '0, data_t'(16'h0f00 + r * 16'h0321));
        end
        drain();
        read_back_all();
        end_test("load immediate");

        dispatch(OP_LI, 3'd1, '0, '0, 16'h1234);
        dispatch(OP_ADD, 3'd2, 3'd1, 3'd1, '0);   // r1 still in flight
        dispatch(OP_SUB, 3'd3, 3'd2, 3'd1, '0);
        dispatch(OP_XOR, 3'd4, 3'd3, 3'd2, '0);
        drain();
        dispatch(OP_LI, 3'd5, '0, '0, 16'h00ff);
        wait_broadcast();
        dispatch(OP_ADD, 3'd6, 3'd5, 3'd5, '0);   // captured from the bus
        dispatch(OP_XOR, 3'd7, 3'd6, 3'd5, '0);
        drain();
        end_test("dependent alu chains");

        dispatch(OP_MUL, 3'd1, 3'd2, 3'd3, '0);
        dispatch(OP_MUL, 3'd4, 3'd5, 3'd6, '0);
        dispatch(OP_ADD, 3'd5, 3'd2, 3'd3, '0);
        dispatch(OP_MUL, 3'd6, 3'd1, 3'd4, '0);
        dispatch(OP_XOR, 3'd7, 3'd6, 3'd1, '0);
        dispatch(OP_SUB, 3'd0, 3'd5, 3'd7, '0);
        drain();
        read_back_all();
        end_test("pipelined multiplies");

        dispatch(OP_MUL, 3'd2, 3'd3, 3'd4, '0);   // slow first writer
        dispatch(OP_ADD, 3'd6, 3'd2, 3'd2, '0);   // reads the first writer
        dispatch(OP_LI, 3'd2, '0, '0, 16'h0bad);
        dispatch(OP_ADD, 3'd5, 3'd2, 3'd1, '0);   // reads the later writer
        drain();
        read_back_all();
        end_test("register renaming");

        dispatch(OP_MUL, 3'd1, 3'd1, 3'd2, '0);
        dispatch(OP_MUL, 3'd3, 3'd3, 3'd3, '0);
        dispatch(OP_ADD, 3'd4, 3'd1, 3'd3, '0);
        dispatch(OP_SUB, 3'd5, 3'd1, 3'd3, '0);   // both classes full here
        drain();
        end_test("availability flags");

        run_random(RANDOM_COUNT);
        drain();
        read_back_all();
        end_test("random stream");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_num, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/ooo_pkg.sv
hdl/rename_stage.sv
hdl/reservation_station.sv
hdl/exec_units.sv
hdl/ooo_core.sv
tb/tb_clock_gen.sv
tb/ooo_checker.sv
tb/ooo_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - hdl/ooo_pkg.sv
      - hdl/rename_stage.sv
      - hdl/reservation_station.sv
      - hdl/exec_units.sv
      - hdl/ooo_core.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/ooo_checker.sv
      - tb/ooo_tb.sv
